//--- hw/heapPkg.sv
/*
  Operation and error encodings shared by every unit of the array heap.
  The default sizes are only starting points. The top level passes the real ones down.
*/
package heapPkg;

  parameter int DefaultArrayBits = 2;                   // Four arrays
  parameter int DefaultIndexBits = 2;                   // Four elements per array
  parameter int DefaultDataBits  = 12;

  // --------------------------------------------------
  // Request operations
  typedef enum logic [3:0] {
    Write,
    Read,
    Size,
    Push,
    Pop,
    Resize,
    Alloc,
    Free,
    Index,                                              // Last position holding a key
    Less,
    Greater
  } heapOp;

  // --------------------------------------------------
  // Response error codes
  typedef enum logic [2:0] {
    None,
    NotAllocated,
    OutOfBounds,
    Full,
    Empty,
    TooLarge,
    OutOfMemory
  } heapError;

  // Operations that scan a whole array
  function automatic logic isSearch(heapOp op);
    return op inside {Index, Less, Greater};
  endfunction

endpackage

//--- hw/heapCmdIf.sv
/*
  One command from the controller to the element store.
  The issuer holds valid and the payload until ready. The store is ready only when idle.
*/
`timescale 1ns/10ps

interface heapCmdIf #(
  parameter int ArrayBits = heapPkg::DefaultArrayBits,
  parameter int IndexBits = heapPkg::DefaultIndexBits,
  parameter int DataBits  = heapPkg::DefaultDataBits
) ();
  import heapPkg::*;

  logic                 valid;
  logic                 ready;
  heapOp                op;
  logic [ArrayBits-1:0] arrayId;
  logic [IndexBits-1:0] index;
  logic [DataBits-1:0]  data;                           // Write data, push value, new size or key

  modport issuer (
    output valid, op, arrayId, index, data,
    input  ready
  );

  modport executor (
    input  valid, op, arrayId, index, data,
    output ready
  );

endinterface

//--- hw/arrayAllocator.sv
/*
  Hands out array numbers. Reuse of the most recently freed array comes first,
  then the lowest number never used. allocId and allocError are valid the cycle
  after allocReq or freeReq. isAllocated answers queryArray combinationally.
*/
`timescale 1ns/10ps

module arrayAllocator #(
  parameter int ArrayBits = heapPkg::DefaultArrayBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 allocReq,
  input  logic                 freeReq,
  input  logic [ArrayBits-1:0] queryArray,
  output logic                 isAllocated,
  output logic [ArrayBits-1:0] allocId,
  output heapPkg::heapError    allocError
);
  import heapPkg::*;

  localparam int ArrayCount = 2 ** ArrayBits;

  logic [ArrayBits-1:0]  freeStack [ArrayCount];        // Freed array numbers, top is newest
  logic [ArrayBits:0]    freeTop;                       // Entries on the free stack
  logic [ArrayBits:0]    highWater;                     // Arrays ever handed out fresh
  logic [ArrayCount-1:0] allocFlags;
  logic [ArrayBits-1:0]  popSlot;
  logic [ArrayBits-1:0]  reuseId;

  assign isAllocated = allocFlags[queryArray];
  assign popSlot     = freeTop[ArrayBits-1:0] - 1'b1;
  assign reuseId     = freeStack[popSlot];

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freeTop    <= '0;
      highWater  <= '0;
      allocFlags <= '0;
      allocId    <= '0;
      allocError <= None;
    end else if (allocReq) begin
      if (freeTop != '0) begin                          // Reuse the newest freed array
        allocId             <= reuseId;
        allocFlags[reuseId] <= 1'b1;
        freeTop             <= freeTop - 1'b1;
        allocError          <= None;
      end else if (highWater < ArrayCount) begin        // Never used before
        allocId                               <= highWater[ArrayBits-1:0];
        allocFlags[highWater[ArrayBits-1:0]] <= 1'b1;
        highWater                             <= highWater + 1'b1;
        allocError                            <= None;
      end else begin
        allocId    <= '0;
        allocError <= OutOfMemory;
      end
    end else if (freeReq) begin
      if (isAllocated) begin
        allocFlags[queryArray] <= 1'b0;
        freeTop                <= freeTop + 1'b1;
        allocError             <= None;
      end else begin
        allocError <= NotAllocated;                     // Double free or never allocated
      end
    end
  end

  // Stack cannot overflow since only allocated arrays are pushed
  always_ff @(posedge clock) begin
    if (freeReq && isAllocated) begin
      freeStack[freeTop[ArrayBits-1:0]] <= queryArray;
    end
  end

endmodule

//--- hw/searchUnit.sv
/*
  Scans one array a position per cycle across the full array length.
  Positions at or beyond scanSize are skipped. scanData must follow scanIndex
  in the same cycle. scanCount is valid while scanDone is high.
*/
`timescale 1ns/10ps

module searchUnit #(
  parameter int IndexBits = heapPkg::DefaultIndexBits,
  parameter int DataBits  = heapPkg::DefaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 scanStart,
  input  heapPkg::heapOp       scanOp,
  input  logic [DataBits-1:0]  scanKey,
  input  logic [IndexBits:0]   scanSize,
  output logic [IndexBits-1:0] scanIndex,
  input  logic [DataBits-1:0]  scanData,
  output logic                 scanDone,
  output logic [IndexBits:0]   scanCount
);
  import heapPkg::*;

  localparam int ArrayLength = 2 ** IndexBits;

  logic                busy;
  heapOp               opHeld;
  logic [DataBits-1:0] keyHeld;
  logic [IndexBits:0]  sizeHeld;
  logic                inRange;
  logic                lastPos;

  assign inRange = {1'b0, scanIndex} < sizeHeld;
  assign lastPos = scanIndex == IndexBits'(ArrayLength - 1);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      busy      <= 1'b0;
      scanDone  <= 1'b0;
      scanIndex <= '0;
      scanCount <= '0;
    end else begin
      scanDone <= 1'b0;
      if (scanStart) begin
        busy      <= 1'b1;
        scanIndex <= '0;
        scanCount <= '0;
      end else if (busy) begin
        if (inRange) begin
          case (opHeld)
            Index:   if (scanData == keyHeld) scanCount <= {1'b0, scanIndex} + 1'b1;
            Less:    if (scanData < keyHeld) scanCount <= scanCount + 1'b1;
            Greater: if (scanData > keyHeld) scanCount <= scanCount + 1'b1;
            default: ;
          endcase
        end
        scanIndex <= scanIndex + 1'b1;
        if (lastPos) begin
          busy     <= 1'b0;
          scanDone <= 1'b1;                             // Count settles on this edge
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (scanStart) begin
      opHeld   <= scanOp;
      keyHeld  <= scanKey;
      sizeHeld <= scanSize;
    end
  end

endmodule

//--- hw/elementStore.sv
/*
  Element memory and per-array size table. The controller has already checked
  allocation. Element commands finish one cycle after acceptance. Searches start
  on the accepting edge and finish when the scan does.
*/
`timescale 1ns/10ps

module elementStore #(
  parameter int ArrayBits = heapPkg::DefaultArrayBits,
  parameter int IndexBits = heapPkg::DefaultIndexBits,
  parameter int DataBits  = heapPkg::DefaultDataBits
) (
  input  logic                clock,
  input  logic                resetN,
  heapCmdIf.executor          cmd,
  output logic                storeDone,
  output logic [DataBits-1:0] storeResult,
  output heapPkg::heapError   storeError
);
  import heapPkg::*;

  localparam int ArrayLength = 2 ** IndexBits;
  localparam int ArrayCount  = 2 ** ArrayBits;

  typedef enum logic [1:0] {StoreIdle, StoreExec, StoreScan} storeState;

  storeState                      state;
  logic [DataBits-1:0]            memory [ArrayCount*ArrayLength];
  logic [IndexBits:0]             sizeTable [ArrayCount];
  heapOp                          opReg;
  logic [ArrayBits-1:0]           arrayReg;
  logic [IndexBits-1:0]           indexReg;
  logic [DataBits-1:0]            dataReg;
  logic [IndexBits:0]             curSize;
  logic [IndexBits:0]             nextSize;
  logic [IndexBits-1:0]           popIdx;
  logic [ArrayBits+IndexBits-1:0] memAddr;
  logic [DataBits-1:0]            memRdData;
  logic [DataBits-1:0]            execResult;
  heapError                       execError;
  logic                           memWe;
  logic                           sizeWe;
  logic                           accept;
  logic                           scanStart;
  logic [IndexBits-1:0]           scanIndex;
  logic [DataBits-1:0]            scanData;
  logic                           scanDone;
  logic [IndexBits:0]             scanCount;

  assign cmd.ready = state == StoreIdle;
  assign accept    = cmd.valid && cmd.ready;
  assign scanStart = accept && isSearch(cmd.op);
  assign scanData  = memory[{arrayReg, scanIndex}];    // Array id is latched with the start
  assign curSize   = sizeTable[arrayReg];
  assign popIdx    = curSize[IndexBits-1:0] - 1'b1;

  searchUnit #(.IndexBits(IndexBits), .DataBits(DataBits)) search (
    .clock     (clock),
    .resetN    (resetN),
    .scanStart (scanStart),
    .scanOp    (cmd.op),
    .scanKey   (cmd.data),
    .scanSize  (sizeTable[cmd.arrayId]),
    .scanIndex (scanIndex),
    .scanData  (scanData),
    .scanDone  (scanDone),
    .scanCount (scanCount)
  );

  // --------------------------------------------------
  // Element command decode
  always_comb begin
    case (opReg)
      Push:    memAddr = {arrayReg, curSize[IndexBits-1:0]};
      Pop:     memAddr = {arrayReg, popIdx};
      default: memAddr = {arrayReg, indexReg};
    endcase
  end

  assign memRdData = memory[memAddr];

  always_comb begin
    execResult = '0;
    execError  = None;
    memWe      = 1'b0;
    sizeWe     = 1'b0;
    nextSize   = curSize;
    case (opReg)
      Write: begin
        memWe      = 1'b1;
        execResult = dataReg;
        if ({1'b0, indexReg} >= curSize) begin          // Writing past the end grows the array
          sizeWe   = 1'b1;
          nextSize = {1'b0, indexReg} + 1'b1;
        end
      end
      Read: begin
        if ({1'b0, indexReg} >= curSize) execError = OutOfBounds;
        else execResult = memRdData;
      end
      Size: execResult = DataBits'(curSize);
      Push: begin
        if (curSize == ArrayLength) begin
          execError = Full;
        end else begin
          memWe      = 1'b1;
          sizeWe     = 1'b1;
          nextSize   = curSize + 1'b1;
          execResult = DataBits'(nextSize);
        end
      end
      Pop: begin
        if (curSize == '0) begin
          execError = Empty;
        end else begin
          sizeWe     = 1'b1;
          nextSize   = curSize - 1'b1;
          execResult = memRdData;
        end
      end
      Resize: begin
        if (dataReg > ArrayLength) begin
          execError = TooLarge;
        end else begin
          sizeWe     = 1'b1;
          nextSize   = dataReg[IndexBits:0];
          execResult = DataBits'(nextSize);
        end
      end
      Alloc: sizeWe = 1'b1;                             // Fresh array starts empty
      default: ;
    endcase
    if (opReg == Alloc) nextSize = '0;
  end

  // --------------------------------------------------
  // State, size table and outcome
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state     <= StoreIdle;
      storeDone <= 1'b0;
      for (int i = 0; i < ArrayCount; i++) begin
        sizeTable[i] <= '0;
      end
    end else begin
      storeDone <= (state == StoreExec) || (state == StoreScan && scanDone);
      case (state)
        StoreIdle: if (accept) state <= isSearch(cmd.op) ? StoreScan : StoreExec;
        StoreExec: begin
          if (sizeWe) sizeTable[arrayReg] <= nextSize;
          state <= StoreIdle;
        end
        StoreScan: if (scanDone) state <= StoreIdle;
        default:   state <= StoreIdle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      opReg    <= cmd.op;
      arrayReg <= cmd.arrayId;
      indexReg <= cmd.index;
      dataReg  <= cmd.data;
    end
    if (state == StoreExec && memWe) memory[memAddr] <= dataReg;
    if (state == StoreExec) begin
      storeResult <= execResult;
      storeError  <= execError;
    end else if (state == StoreScan && scanDone) begin
      storeResult <= DataBits'(scanCount);
      storeError  <= None;
    end
  end

endmodule

//--- hw/heapController.sv
/*
  Takes one request at a time and holds its response until rspReady.
  Alloc and Free go to the allocator, everything else to the store once the
  array is known to be allocated. Alloc also clears the new array's size.
*/
`timescale 1ns/10ps

module heapController #(
  parameter int ArrayBits = heapPkg::DefaultArrayBits,
  parameter int IndexBits = heapPkg::DefaultIndexBits,
  parameter int DataBits  = heapPkg::DefaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 reqValid,
  output logic                 reqReady,
  input  heapPkg::heapOp       reqOp,
  input  logic [ArrayBits-1:0] reqArray,
  input  logic [IndexBits-1:0] reqIndex,
  input  logic [DataBits-1:0]  reqData,
  output logic                 rspValid,
  input  logic                 rspReady,
  output logic [DataBits-1:0]  rspData,
  output heapPkg::heapError    rspError,
  heapCmdIf.issuer             cmd,
  input  logic                 storeDone,
  input  logic [DataBits-1:0]  storeResult,
  input  heapPkg::heapError    storeError,
  output logic                 allocReq,
  output logic                 freeReq,
  output logic [ArrayBits-1:0] queryArray,
  input  logic                 isAllocated,
  input  logic [ArrayBits-1:0] allocId,
  input  heapPkg::heapError    allocError
);
  import heapPkg::*;

  typedef enum logic [1:0] {CtlIdle, CtlDispatch, CtlWait, CtlRespond} ctlState;

  ctlState              state;
  heapOp                opReg;
  logic [ArrayBits-1:0] arrayReg;
  logic [IndexBits-1:0] indexReg;
  logic [DataBits-1:0]  dataReg;
  logic                 notAlloc;                       // Element op on a free array
  logic                 isMgmt;
  logic                 loadRsp;
  logic [DataBits-1:0]  nextData;
  heapError             nextError;

  assign reqReady   = state == CtlIdle;
  assign rspValid   = state == CtlRespond;
  assign queryArray = arrayReg;
  assign isMgmt     = opReg inside {Alloc, Free};
  assign allocReq   = state == CtlDispatch && opReg == Alloc;
  assign freeReq    = state == CtlDispatch && opReg == Free;

  // Element ops go out in dispatch, the size clear for Alloc goes out in wait
  assign cmd.valid   = (state == CtlDispatch && !isMgmt && isAllocated)
                    || (state == CtlWait && opReg == Alloc && allocError == None);
  assign cmd.op      = opReg;
  assign cmd.arrayId = (opReg == Alloc) ? allocId : arrayReg;
  assign cmd.index   = indexReg;
  assign cmd.data    = dataReg;

  always_comb begin
    loadRsp   = 1'b0;
    nextData  = '0;
    nextError = None;
    if (state == CtlWait) begin
      if (opReg == Alloc) begin
        nextError = allocError;
        if (allocError == None) nextData = DataBits'(allocId);
        loadRsp = (allocError != None) || cmd.ready;
      end else if (opReg == Free) begin
        nextError = allocError;
        loadRsp   = 1'b1;
      end else if (notAlloc) begin
        nextError = NotAllocated;
        loadRsp   = 1'b1;
      end else begin
        nextData  = storeResult;
        nextError = storeError;
        loadRsp   = storeDone;
      end
    end
  end

  // --------------------------------------------------
  // Request FSM
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state    <= CtlIdle;
      notAlloc <= 1'b0;
    end else begin
      case (state)
        CtlIdle: if (reqValid) state <= CtlDispatch;
        CtlDispatch: begin
          notAlloc <= !isMgmt && !isAllocated;
          if (isMgmt || !isAllocated || cmd.ready) state <= CtlWait;
        end
        CtlWait:    if (loadRsp) state <= CtlRespond;
        CtlRespond: if (rspReady) state <= CtlIdle;
        default:    state <= CtlIdle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid && reqReady) begin
      opReg    <= reqOp;
      arrayReg <= reqArray;
      indexReg <= reqIndex;
      dataReg  <= reqData;
    end
    if (loadRsp) begin                                  // Held through back-pressure
      rspData  <= nextData;
      rspError <= nextError;
    end
  end

endmodule

//--- hw/arrayHeap.sv
/*
  Array heap unit with valid/ready request and response channels.
  One request is in flight at a time. Search latency grows with the array length.
*/
`timescale 1ns/10ps

module arrayHeap #(
  parameter int ArrayBits = heapPkg::DefaultArrayBits,
  parameter int IndexBits = heapPkg::DefaultIndexBits,
  parameter int DataBits  = heapPkg::DefaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 reqValid,
  output logic                 reqReady,
  input  heapPkg::heapOp       reqOp,
  input  logic [ArrayBits-1:0] reqArray,
  input  logic [IndexBits-1:0] reqIndex,
  input  logic [DataBits-1:0]  reqData,
  output logic                 rspValid,
  input  logic                 rspReady,
  output logic [DataBits-1:0]  rspData,
  output heapPkg::heapError    rspError
);
  import heapPkg::*;

  logic                 storeDone;
  logic [DataBits-1:0]  storeResult;
  heapError             storeError;
  logic                 allocReq;
  logic                 freeReq;
  logic [ArrayBits-1:0] queryArray;
  logic                 isAllocated;
  logic [ArrayBits-1:0] allocId;
  heapError             allocError;

  heapCmdIf #(.ArrayBits(ArrayBits), .IndexBits(IndexBits), .DataBits(DataBits)) cmdBus ();

  heapController #(.ArrayBits(ArrayBits), .IndexBits(IndexBits), .DataBits(DataBits)) control (
    .clock       (clock),
    .resetN      (resetN),
    .reqValid    (reqValid),
    .reqReady    (reqReady),
    .reqOp       (reqOp),
    .reqArray    (reqArray),
    .reqIndex    (reqIndex),
    .reqData     (reqData),
    .rspValid    (rspValid),
    .rspReady    (rspReady),
    .rspData     (rspData),
    .rspError    (rspError),
    .cmd         (cmdBus.issuer),
    .storeDone   (storeDone),
    .storeResult (storeResult),
    .storeError  (storeError),
    .allocReq    (allocReq),
    .freeReq     (freeReq),
    .queryArray  (queryArray),
    .isAllocated (isAllocated),
    .allocId     (allocId),
    .allocError  (allocError)
  );

  arrayAllocator #(.ArrayBits(ArrayBits)) allocator (
    .clock       (clock),
    .resetN      (resetN),
    .allocReq    (allocReq),
    .freeReq     (freeReq),
    .queryArray  (queryArray),
    .isAllocated (isAllocated),
    .allocId     (allocId),
    .allocError  (allocError)
  );

  elementStore #(.ArrayBits(ArrayBits), .IndexBits(IndexBits), .DataBits(DataBits)) store (
    .clock       (clock),
    .resetN      (resetN),
    .cmd         (cmdBus.executor),
    .storeDone   (storeDone),
    .storeResult (storeResult),
    .storeError  (storeError)
  );

endmodule

//--- tests/arrayHeapTb.sv
/*
  Plays tests/heapStim.txt against the array heap, one request per line.
  Run from the project root. The stimulus assumes four arrays of four elements.
*/
`timescale 1ns/10ps

module arrayHeapTb;
  import heapPkg::*;

  localparam int ArrayBits   = 2;
  localparam int IndexBits   = 2;
  localparam int DataBits    = 12;
  localparam int ArrayLength = 2 ** IndexBits;
  localparam int ClockPeriod = 100;
  localparam int ResetCycles = 3;

  logic                 clock;
  logic                 resetN;
  logic                 reqValid;
  logic                 reqReady;
  heapOp                reqOp;
  logic [ArrayBits-1:0] reqArray;
  logic [IndexBits-1:0] reqIndex;
  logic [DataBits-1:0]  reqData;
  logic                 rspValid;
  logic                 rspReady;
  logic [DataBits-1:0]  rspData;
  heapError             rspError;

  string    testName [$];                               // One entry per stimulus line
  heapOp    opQ [$];
  int       arrayQ [$];
  int       indexQ [$];
  int       dataQ [$];
  int       expResultQ [$];
  heapError expErrorQ [$];
  int       seed;
  int       errorCount;
  int       checkCount;
  bit       loaded;

  arrayHeap #(.ArrayBits(ArrayBits), .IndexBits(IndexBits), .DataBits(DataBits)) UUT (
    .clock    (clock),
    .resetN   (resetN),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .reqOp    (reqOp),
    .reqArray (reqArray),
    .reqIndex (reqIndex),
    .reqData  (reqData),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rspData  (rspData),
    .rspError (rspError)
  );

  initial begin
    clock = 1'b0;
    forever #(ClockPeriod / 2) clock = ~clock;
  end

  task automatic compareValue(input string test, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("FAIL %s %s: expected %0d, actual %0d", test, field, expected, actual);
    end
  endtask

  // --------------------------------------------------
  // Stimulus file decoding
  task automatic decodeOp(input string name, output heapOp op, output bit found);
    heapOp probe;
    found = 1'b0;
    probe = probe.first();
    op    = probe;
    for (int i = 0; i < probe.num(); i++) begin
      if (probe.name() == name) begin
        op    = probe;
        found = 1'b1;
      end
      probe = probe.next();
    end
  endtask

  task automatic decodeError(input string name, output heapError err, output bit found);
    heapError probe;
    found = 1'b0;
    probe = probe.first();
    err   = probe;
    for (int i = 0; i < probe.num(); i++) begin
      if (probe.name() == name) begin
        err   = probe;
        found = 1'b1;
      end
      probe = probe.next();
    end
  endtask

  task automatic loadStimulus();
    int       fd;
    int       count;
    int       arrayId;
    int       index;
    int       data;
    int       result;
    string    line;
    string    name;
    string    opName;
    string    errName;
    heapOp    op;
    heapError err;
    bit       opOk;
    bit       errOk;
    fd = $fopen("tests/heapStim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file tests/heapStim.txt");
      errorCount++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line[0] == "#") continue;
      count = $sscanf(line, "%s %s %d %d %d %d %s",
                      name, opName, arrayId, index, data, result, errName);
      if (count <= 0) continue;                         // Blank line
      decodeOp(opName, op, opOk);
      decodeError(errName, err, errOk);
      if (count != 7 || !opOk || !errOk) begin
        $display("Malformed stimulus line: %s", line);
        errorCount++;
      end else begin
        testName.push_back(name);
        opQ.push_back(op);
        arrayQ.push_back(arrayId);
        indexQ.push_back(index);
        dataQ.push_back(data);
        expResultQ.push_back(result);
        expErrorQ.push_back(err);
      end
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------
  // Request player and response checker
  task automatic sendRequests();
    foreach (testName[i]) begin
      @(posedge clock);
      reqValid <= 1'b1;
      reqOp    <= opQ[i];
      reqArray <= ArrayBits'(arrayQ[i]);
      reqIndex <= IndexBits'(indexQ[i]);
      reqData  <= DataBits'(dataQ[i]);
      do @(negedge clock); while (!reqReady);
      @(posedge clock);                                 // Transfer edge
      reqValid <= 1'b0;
    end
  endtask

  task automatic collectResponses();
    bit                  done;
    bit                  held;
    logic [DataBits-1:0] heldData;
    heapError            heldError;
    foreach (testName[i]) begin
      done = 1'b0;
      held = 1'b0;
      while (!done) begin
        @(posedge clock);
        rspReady <= ($random(seed) & 3) != 0;           // Stall about one cycle in four
        @(negedge clock);
        if (rspValid) begin                             // No new request while responding
          compareValue(testName[i], "reqReady", 0, reqReady);
        end
        if (rspValid && held) begin
          compareValue(testName[i], "held result", heldData, rspData);
          compareValue(testName[i], "held error", heldError, rspError);
        end
        if (rspValid && rspReady) begin
          done = 1'b1;
        end else if (rspValid) begin
          held      = 1'b1;
          heldData  = rspData;
          heldError = rspError;
        end
      end
      compareValue(testName[i], "result", expResultQ[i], rspData);
      compareValue(testName[i], "error", expErrorQ[i], rspError);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  initial begin
    seed       = 96037;
    resetN     = 1'b0;
    reqValid   = 1'b0;
    reqOp      = Write;
    reqArray   = '0;
    reqIndex   = '0;
    reqData    = '0;
    rspReady   = 1'b0;
    errorCount = 0;
    checkCount = 0;
    loadStimulus();
    if (testName.size() == 0) begin
      $display("No requests were read from the stimulus file");
      errorCount++;
    end
    loaded = 1'b1;
    repeat (ResetCycles) @(posedge clock);
    resetN <= 1'b1;
    @(negedge clock);
    compareValue("reset", "reqReady", 1, reqReady);
    compareValue("reset", "rspValid", 0, rspValid);
    fork
      sendRequests();
      collectResponses();
    join
    repeat (2) @(negedge clock);
    compareValue("drain", "rspValid", 0, rspValid);     // No extra response
    $display("Requests: %0d, checks: %0d, errors: %0d",
             testName.size(), checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Longest request is a search plus stalls, well inside ArrayLength + 20 cycles
  initial begin
    longint limit;
    wait (loaded);
    limit = (longint'(testName.size()) * (ArrayLength + 20) + ResetCycles + 4) * ClockPeriod;
    #(limit);
    $display("Timeout: the DUT did not finish %0d requests within %0d ns",
             testName.size(), limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- tests/heapStim.txt
# test op array index data expectedResult expectedError
# Operations and error codes by name, numbers in decimal
alloc0        Alloc    0 0   0    0 None
alloc1        Alloc    0 0   0    1 None
alloc2        Alloc    0 0   0    2 None
alloc3        Alloc    0 0   0    3 None
allocOom      Alloc    0 0   0    0 OutOfMemory
free1         Free     1 0   0    0 None
free2         Free     2 0   0    0 None
reuse2        Alloc    0 0   0    2 None
reuse1        Alloc    0 0   0    1 None
free3         Free     3 0   0    0 None
freeAgain3    Free     3 0   0    0 NotAllocated
write10       Write    0 0  10   10 None
write20       Write    0 1  20   20 None
write30       Write    0 2  30   30 None
resize3       Resize   0 0   3    3 None
index30       Index    0 0  30    3 None
index20       Index    0 0  20    2 None
index10       Index    0 0  10    1 None
index15       Index    0 0  15    0 None
less35        Less     0 0  35    3 None
less25        Less     0 0  25    2 None
less15        Less     0 0  15    1 None
less5         Less     0 0   5    0 None
greater35     Greater  0 0  35    0 None
greater25     Greater  0 0  25    1 None
greater15     Greater  0 0  15    2 None
greater5      Greater  0 0   5    3 None
growWrite     Write    1 2   7    7 None
growSize      Size     1 0   0    3 None
readPast      Read     1 3   0    0 OutOfBounds
readLast      Read     1 2   0    7 None
resizeBig     Resize   1 0   5    0 TooLarge
sizeKept      Size     1 0   0    3 None
push100       Push     2 0 100    1 None
push200       Push     2 0 200    2 None
push300       Push     2 0 300    3 None
push400       Push     2 0 400    4 None
pushFull      Push     2 0 500    0 Full
pop400        Pop      2 0   0  400 None
pop300        Pop      2 0   0  300 None
pop200        Pop      2 0   0  200 None
pop100        Pop      2 0   0  100 None
popEmpty      Pop      2 0   0    0 Empty
unallocWrite  Write    3 0   5    0 NotAllocated
unallocRead   Read     3 0   0    0 NotAllocated
unallocSize   Size     3 0   0    0 NotAllocated
unallocPush   Push     3 0   5    0 NotAllocated
unallocPop    Pop      3 0   0    0 NotAllocated
unallocResize Resize   3 0   2    0 NotAllocated
unallocLess   Less     3 0   9    0 NotAllocated
stateKept     Size     0 0   0    3 None

//--- sim.f
hw/heapPkg.sv
hw/heapCmdIf.sv
hw/arrayAllocator.sv
hw/searchUnit.sv
hw/elementStore.sv
hw/heapController.sv
hw/arrayHeap.sv
tests/arrayHeapTb.sv

//--- Bender.yml
package:
  name: array_heap

sources:
  - files:
      - hw/heapPkg.sv
      - hw/heapCmdIf.sv
      - hw/arrayAllocator.sv
      - hw/searchUnit.sv
      - hw/elementStore.sv
      - hw/heapController.sv
      - hw/arrayHeap.sv
  - target: test
    files:
      - tests/arrayHeapTb.sv
